// ==== include/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// request credits handed to the core after reset
`define LSU_CREDITS 2

// mtime window, both bounds inclusive
`define CLINT_BASE 32'ha000_0048
`define CLINT_END  32'ha000_004f

`define AXI_ID 4'd0

`endif

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // core-side byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // one bit per byte lane
    typedef logic [3:0] strb_t;

    // access size as sent by the core
    // 0 means no access and never appears on a valid request
    typedef logic [1:0] lsu_size_t;

    localparam lsu_size_t lsu_size_byte = 2'd1;
    localparam lsu_size_t lsu_size_half = 2'd2;
    localparam lsu_size_t lsu_size_word = 2'd3;

    // request credits and queue occupancy
    typedef logic [1:0] credit_cnt_t;

endpackage

// ==== design/axi_pkg.sv ====
package axi_pkg;

    typedef logic [1:0] axi_resp_t;
    typedef logic [2:0] axi_size_t;

    localparam axi_resp_t axi_resp_okay   = 2'b00;
    localparam axi_resp_t axi_resp_slverr = 2'b10;

    localparam logic [1:0] axi_burst_incr = 2'b01;

    // single-beat master, read path or write path
    typedef enum logic [2:0] {
        idle,
        addr_rd,
        data_rd,
        addr_wr,
        data_wr,
        resp_wr
    } axi_state_t;

endpackage

// ==== design/lsu_req_queue.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_queue
    import lsu_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  logic       req_we,
    input  logic       req_sign,
    input  lsu_size_t  req_size,
    input  addr_t      req_addr,
    input  data_t      req_wdata,
    input  logic       done,
    output logic       clint_sel,
    output logic       bus_start,
    output logic       is_write,
    output addr_t      iss_addr,
    output data_t      iss_wdata,
    output strb_t      iss_strb,
    output axi_size_t  iss_size,
    output logic [1:0] tag_off,
    output lsu_size_t  tag_size,
    output logic       tag_sign
);

    localparam int DEPTH = `LSU_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic       q_we    [DEPTH];
    logic       q_sign  [DEPTH];
    lsu_size_t  q_size  [DEPTH];
    addr_t      q_addr  [DEPTH];
    data_t      q_wdata [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_cnt_t      count;
    logic             busy;
    logic             issue;
    logic             is_clint;
    lsu_size_t        head_size;
    logic [1:0]       off;

    // one access in flight at a time
    assign issue = !busy && (count != '0);

    assign head_size = q_size[rd_ptr];
    assign is_write  = q_we[rd_ptr];
    assign iss_addr  = q_addr[rd_ptr];
    assign off       = iss_addr[1:0];

    assign is_clint  = (iss_addr >= `CLINT_BASE) && (iss_addr <= `CLINT_END);
    assign clint_sel = issue && is_clint;
    assign bus_start = issue && !is_clint;

    // move store data into its byte lane
    assign iss_wdata = q_wdata[rd_ptr] << {off, 3'b000};
    assign iss_size  = {1'b0, head_size - 2'd1};

    always_comb begin
        case (head_size)
            lsu_size_byte: iss_strb = strb_t'(4'b0001 << off);
            lsu_size_half: iss_strb = off[1] ? 4'b1100 : 4'b0011;
            lsu_size_word: iss_strb = 4'b1111;
            default:       iss_strb = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            busy   <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, issue})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            // busy until the merge reports the response
            if (issue) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_we[wr_ptr]    <= req_we;
            q_sign[wr_ptr]  <= req_sign;
            q_size[wr_ptr]  <= req_size;
            q_addr[wr_ptr]  <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
        end
        // pending tag for the load extension
        if (issue) begin
            tag_off  <= off;
            tag_size <= head_size;
            tag_sign <= q_sign[rd_ptr];
        end
    end

endmodule

// ==== design/clint_regs.sv ====
`timescale 1ns/1ps

module clint_regs
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  clint_sel,
    input  logic  is_write,
    input  addr_t iss_addr,
    input  data_t iss_wdata,
    output logic  clint_rvalid,
    output data_t clint_rdata
);

    logic [63:0] mtime;
    logic [63:0] mtime_inc;
    logic        hi_sel;
    logic        wr_en;

    assign mtime_inc = mtime + 64'd1;
    // bit 2 picks mtimeh
    assign hi_sel    = iss_addr[2];
    assign wr_en     = clint_sel && is_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime        <= '0;
            clint_rvalid <= 1'b0;
        end else begin
            clint_rvalid <= clint_sel;
            // written word takes the store value, the other keeps counting
            if (wr_en && hi_sel) begin
                mtime <= {iss_wdata, mtime_inc[31:0]};
            end else if (wr_en) begin
                mtime <= {mtime_inc[63:32], iss_wdata};
            end else begin
                mtime <= mtime_inc;
            end
        end
    end

    // write completions return this too, the merge drops it
    always_ff @(posedge clk) begin
        if (clint_sel) begin
            clint_rdata <= hi_sel ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// ==== design/axi_single_master.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module axi_single_master
    import lsu_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       bus_start,
    input  logic       is_write,
    input  addr_t      iss_addr,
    input  data_t      iss_wdata,
    input  strb_t      iss_strb,
    input  axi_size_t  iss_size,
    input  logic       awready,
    output logic       awvalid,
    output addr_t      awaddr,
    output logic [3:0] awid,
    output logic [7:0] awlen,
    output axi_size_t  awsize,
    output logic [1:0] awburst,
    input  logic       wready,
    output logic       wvalid,
    output data_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    input  logic       bvalid,
    output logic       bready,
    input  axi_resp_t  bresp,
    input  logic [3:0] bid,
    input  logic       arready,
    output logic       arvalid,
    output addr_t      araddr,
    output logic [3:0] arid,
    output logic [7:0] arlen,
    output axi_size_t  arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  data_t      rdata,
    input  axi_resp_t  rresp,
    input  logic       rlast,
    input  logic [3:0] rid,
    output logic       bus_done,
    output data_t      bus_rdata,
    output axi_resp_t  bus_resp
);

    axi_state_t state;
    axi_state_t state_nxt;
    addr_t      addr_q;
    data_t      wdata_q;
    strb_t      strb_q;
    axi_size_t  size_q;
    logic       rd_ok;
    logic       wr_ok;

    // a beat with the wrong id or no last is treated as a slave error
    assign rd_ok = rlast && (rid == `AXI_ID);
    assign wr_ok = (bid == `AXI_ID);

    assign arvalid = (state == addr_rd);
    assign rready  = (state == data_rd);
    assign awvalid = (state == addr_wr);
    assign wvalid  = (state == data_wr);
    assign wlast   = (state == data_wr);
    assign bready  = (state == resp_wr);

    assign araddr  = addr_q;
    assign arsize  = size_q;
    assign arid    = `AXI_ID;
    assign arlen   = 8'd0;
    assign arburst = axi_burst_incr;
    assign awaddr  = addr_q;
    assign awsize  = size_q;
    assign awid    = `AXI_ID;
    assign awlen   = 8'd0;
    assign awburst = axi_burst_incr;
    assign wdata   = wdata_q;
    assign wstrb   = strb_q;

    always_comb begin
        state_nxt = state;
        case (state)
            idle:    if (bus_start) state_nxt = is_write ? addr_wr : addr_rd;
            addr_rd: if (arready) state_nxt = data_rd;
            data_rd: if (rvalid) state_nxt = idle;
            addr_wr: if (awready) state_nxt = data_wr;
            data_wr: if (wready) state_nxt = resp_wr;
            resp_wr: if (bvalid) state_nxt = idle;
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            bus_done <= 1'b0;
        end else begin
            state    <= state_nxt;
            bus_done <= (rready && rvalid) || (bready && bvalid);
        end
    end

    always_ff @(posedge clk) begin
        if (bus_start) begin
            addr_q  <= iss_addr;
            wdata_q <= iss_wdata;
            strb_q  <= iss_strb;
            size_q  <= iss_size;
        end
        if (rready && rvalid) begin
            bus_rdata <= rdata;
            bus_resp  <= rd_ok ? rresp : axi_resp_slverr;
        end
        if (bready && bvalid) begin
            bus_resp <= wr_ok ? bresp : axi_resp_slverr;
        end
    end

endmodule

// ==== design/lsu_resp_merge.sv ====
`timescale 1ns/1ps

module lsu_resp_merge
    import lsu_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clint_rvalid,
    input  data_t      clint_rdata,
    input  logic       bus_done,
    input  data_t      bus_rdata,
    input  axi_resp_t  bus_resp,
    input  logic [1:0] tag_off,
    input  lsu_size_t  tag_size,
    input  logic       tag_sign,
    output logic       done,
    output logic       resp_valid,
    output logic       resp_err,
    output logic       credit_return,
    output data_t      resp_rdata
);

    logic  cpl;
    logic  valid_q;
    data_t raw;
    data_t shifted;
    data_t ext;

    // only one target can complete at a time
    assign cpl     = clint_rvalid || bus_done;
    assign raw     = clint_rvalid ? clint_rdata : bus_rdata;
    assign shifted = raw >> {tag_off, 3'b000};

    always_comb begin
        case (tag_size)
            lsu_size_byte: ext = {{24{shifted[7] & tag_sign}}, shifted[7:0]};
            lsu_size_half: ext = {{16{shifted[15] & tag_sign}}, shifted[15:0]};
            default:       ext = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cpl;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl) begin
            resp_rdata <= ext;
            resp_err   <= bus_done && (bus_resp != axi_resp_okay);
        end
    end

    // one credit back per response, and the queue may issue again
    assign resp_valid    = valid_q;
    assign credit_return = valid_q;
    assign done          = valid_q;

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  logic       req_we,
    input  logic       req_sign,
    input  lsu_size_t  req_size,
    input  addr_t      req_addr,
    input  data_t      req_wdata,
    output logic       resp_valid,
    output logic       resp_err,
    output logic       credit_return,
    output data_t      resp_rdata,
    output logic       awvalid,
    input  logic       awready,
    output addr_t      awaddr,
    output logic [3:0] awid,
    output logic [7:0] awlen,
    output axi_size_t  awsize,
    output logic [1:0] awburst,
    output logic       wvalid,
    input  logic       wready,
    output data_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    input  logic       bvalid,
    output logic       bready,
    input  axi_resp_t  bresp,
    input  logic [3:0] bid,
    output logic       arvalid,
    input  logic       arready,
    output addr_t      araddr,
    output logic [3:0] arid,
    output logic [7:0] arlen,
    output axi_size_t  arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  data_t      rdata,
    input  axi_resp_t  rresp,
    input  logic       rlast,
    input  logic [3:0] rid
);

    logic       clint_sel;
    logic       bus_start;
    logic       is_write;
    addr_t      iss_addr;
    data_t      iss_wdata;
    strb_t      iss_strb;
    axi_size_t  iss_size;
    logic [1:0] tag_off;
    lsu_size_t  tag_size;
    logic       tag_sign;
    logic       done;
    logic       clint_rvalid;
    data_t      clint_rdata;
    logic       bus_done;
    data_t      bus_rdata;
    axi_resp_t  bus_resp;

    lsu_req_queue u_req_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_we    (req_we),
        .req_sign  (req_sign),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .done      (done),
        .clint_sel (clint_sel),
        .bus_start (bus_start),
        .is_write  (is_write),
        .iss_addr  (iss_addr),
        .iss_wdata (iss_wdata),
        .iss_strb  (iss_strb),
        .iss_size  (iss_size),
        .tag_off   (tag_off),
        .tag_size  (tag_size),
        .tag_sign  (tag_sign)
    );

    clint_regs u_clint_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .clint_sel    (clint_sel),
        .is_write     (is_write),
        .iss_addr     (iss_addr),
        .iss_wdata    (iss_wdata),
        .clint_rvalid (clint_rvalid),
        .clint_rdata  (clint_rdata)
    );

    axi_single_master u_axi_master (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus_start (bus_start),
        .is_write  (is_write),
        .iss_addr  (iss_addr),
        .iss_wdata (iss_wdata),
        .iss_strb  (iss_strb),
        .iss_size  (iss_size),
        .awready   (awready),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awid      (awid),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .wready    (wready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .bid       (bid),
        .arready   (arready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arid      (arid),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rid       (rid),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .bus_resp  (bus_resp)
    );

    lsu_resp_merge u_resp_merge (
        .clk           (clk),
        .arst_n        (arst_n),
        .clint_rvalid  (clint_rvalid),
        .clint_rdata   (clint_rdata),
        .bus_done      (bus_done),
        .bus_rdata     (bus_rdata),
        .bus_resp      (bus_resp),
        .tag_off       (tag_off),
        .tag_size      (tag_size),
        .tag_sign      (tag_sign),
        .done          (done),
        .resp_valid    (resp_valid),
        .resp_err      (resp_err),
        .credit_return (credit_return),
        .resp_rdata    (resp_rdata)
    );

endmodule

// ==== sim/lsu_asserts.sv ====
`timescale 1ns/1ps

module lsu_asserts (
    input logic clk,
    input logic arst_n,
    input logic req_valid,
    input logic resp_valid,
    input logic credit_return,
    input logic awvalid,
    input logic awready,
    input logic arvalid,
    input logic arready
);

    // requests accepted but not yet answered
    int outstanding;
    int n_fail = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid) - int'(resp_valid);
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid)
        else begin
            n_fail++;
            $error("awvalid dropped before its handshake");
        end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid)
        else begin
            n_fail++;
            $error("arvalid dropped before its handshake");
        end

    credit_with_resp: assert property (@(posedge clk) disable iff (!arst_n)
        credit_return == resp_valid)
        else begin
            n_fail++;
            $error("credit_return and resp_valid out of step");
        end

    resp_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> outstanding > 0)
        else begin
            n_fail++;
            $error("response with no request outstanding");
        end

endmodule

bind lsu_top lsu_asserts u_lsu_asserts (
    .clk           (clk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .resp_valid    (resp_valid),
    .credit_return (credit_return),
    .awvalid       (awvalid),
    .awready       (awready),
    .arvalid       (arvalid),
    .arready       (arready)
);

// ==== sim/tb_lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_top
    import lsu_pkg::*;
    import axi_pkg::*;
();

    localparam int clk_period = 100;

    typedef struct packed {
        logic      we;
        lsu_size_t sz;
        logic      sgn;
        addr_t     addr;
        data_t     wdata;
        data_t     exp_data;
        logic      exp_err;
    } row_t;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       req_valid;
    logic       req_we;
    logic       req_sign;
    lsu_size_t  req_size;
    addr_t      req_addr;
    data_t      req_wdata;
    logic       resp_valid;
    logic       resp_err;
    logic       credit_return;
    data_t      resp_rdata;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    logic [3:0] awid;
    logic [7:0] awlen;
    axi_size_t  awsize;
    logic [1:0] awburst;
    logic       wvalid;
    logic       wready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    axi_resp_t  bresp;
    logic [3:0] bid;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic [3:0] arid;
    logic [7:0] arlen;
    axi_size_t  arsize;
    logic [1:0] arburst;
    logic       rvalid;
    logic       rready;
    data_t      rdata;
    axi_resp_t  rresp;
    logic       rlast;
    logic [3:0] rid;

    row_t       rows [$];
    int         exp_q [$];
    // rows that go out on the AXI port, oldest first
    int         axi_q [$];
    logic       rows_ready = 1'b0;
    data_t      mem [256];
    // per-cycle ready and valid gating for the memory model
    logic [3:0] gate [1024];

    lsu_top u_lsu_top (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time=%0t %s got=%h expected=%h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time=%0t %s got=%b expected=%b",
                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time=%0t %s got=%h expected=%h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input axi_size_t got, input axi_size_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time=%0t %s got=%0d expected=%0d",
                $time, name, got, exp));
        end
    endtask

    // fixed AXI fields such as len, burst, id and last
    task automatic check_ctrl(input string name, input logic [7:0] got,
        input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time=%0t %s got=%h expected=%h",
                $time, name, got, exp));
        end
    endtask

    task automatic add_row(input logic we, input lsu_size_t sz, input logic sgn,
        input addr_t addr, input data_t wdata, input data_t exp_data, input logic exp_err);
        rows.push_back(row_t'{we, sz, sgn, addr, wdata, exp_data, exp_err});
    endtask

    // 0x8000_1000 page answers with a slave error
    function automatic logic in_err_page(input addr_t a);
        return a[31:8] == 24'h80_0010;
    endfunction

    // mtime is one aligned 8-byte block
    function automatic logic in_clint(input addr_t a);
        return a[31:3] == 29'(`CLINT_BASE >> 3);
    endfunction

    // AXI size is log2 of the byte count
    function automatic axi_size_t axi_size_for(input lsu_size_t sz);
        case (sz)
            lsu_size_byte: return 3'd0;
            lsu_size_half: return 3'd1;
            default:       return 3'd2;
        endcase
    endfunction

    // address phase against the oldest row still owed to the bus
    task automatic expect_bus_req(input string pfx, input logic we, input addr_t addr,
        input axi_size_t size, input logic [7:0] len, input logic [1:0] burst,
        input logic [3:0] id);
        int ai;
        if (axi_q.size() == 0) begin
            abort_run("AXI address handshake with no bus request outstanding");
        end
        ai = axi_q.pop_front();
        if (rows[ai].we !== we) begin
            abort_run("AXI transfer direction does not match the request");
        end
        check_addr({pfx, "addr"}, addr, rows[ai].addr);
        check_size({pfx, "size"}, size, axi_size_for(rows[ai].sz));
        check_ctrl({pfx, "len"}, len, 8'd0);
        check_ctrl({pfx, "burst"}, burst, 8'd1);
        check_ctrl({pfx, "id"}, id, `AXI_ID);
    endtask

    // single-beat AXI memory, handshakes sampled mid-cycle
    initial begin : axi_mem_model
        int        cyc;
        int        b;
        logic [3:0] g;
        addr_t     aw_q;
        data_t     r_data_q;
        axi_resp_t r_resp_q;
        axi_resp_t b_resp_q;
        logic      r_pend;
        logic      b_pend;
        for (b = 0; b < 256; b++) begin
            mem[b] = (32'h8000_0000 + 32'(b * 4)) ^ 32'h5a5a_0000;
        end
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bresp    = axi_resp_okay;
        bid      = `AXI_ID;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rresp    = axi_resp_okay;
        rlast    = 1'b1;
        rid      = `AXI_ID;
        cyc      = 0;
        aw_q     = '0;
        r_data_q = '0;
        r_resp_q = axi_resp_okay;
        b_resp_q = axi_resp_okay;
        r_pend   = 1'b0;
        b_pend   = 1'b0;
        forever begin
            @(negedge clk);
            if (arvalid && arready) begin
                expect_bus_req("ar", 1'b0, araddr, arsize, arlen, arburst, arid);
                r_data_q = mem[araddr[9:2]];
                r_resp_q = in_err_page(araddr) ? axi_resp_slverr : axi_resp_okay;
                r_pend   = 1'b1;
            end
            if (rvalid && rready) begin
                r_pend = 1'b0;
            end
            if (awvalid && awready) begin
                expect_bus_req("aw", 1'b1, awaddr, awsize, awlen, awburst, awid);
                aw_q = awaddr;
            end
            if (wvalid && wready) begin
                check_ctrl("wlast", wlast, 8'd1);
                for (b = 0; b < 4; b++) begin
                    if (wstrb[b] && !in_err_page(aw_q)) begin
                        mem[aw_q[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
                b_resp_q = in_err_page(aw_q) ? axi_resp_slverr : axi_resp_okay;
                b_pend   = 1'b1;
            end
            if (bvalid && bready) begin
                b_pend = 1'b0;
            end
            @(posedge clk);
            #1;
            g = gate[cyc % 1024];
            cyc++;
            arready = g[0];
            awready = g[1];
            wready  = g[2];
            // once raised, a valid stays up until its handshake
            rvalid  = r_pend && (rvalid || g[3]);
            rdata   = r_data_q;
            rresp   = r_resp_q;
            bvalid  = b_pend && (bvalid || g[3]);
            bresp   = b_resp_q;
        end
    end

    initial begin : watchdog
        wait (rows_ready);
        repeat (rows.size() * 40) @(posedge clk);
        abort_run("timeout: not every request received its response in time");
    end

    initial begin : main
        credit_cnt_t credits;
        int          n_sent;
        int          n_resp;
        int          n_credit;
        int          idx;
        int          i;
        row_t        r;
        void'($urandom(32'h99cfff8f));
        for (i = 0; i < 1024; i++) begin
            gate[i] = 4'($urandom());
        end
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_sign  = 1'b0;
        req_size  = lsu_size_word;
        req_addr  = '0;
        req_wdata = '0;

        // first two rows go out back to back on both credits
        add_row(1, lsu_size_word, 0, 32'h8000_0010, 32'h1122_3344, 32'h0, 0);
        add_row(0, lsu_size_word, 0, 32'h8000_0010, 32'h0, 32'h1122_3344, 0);
        // partial stores into one word
        add_row(1, lsu_size_word, 0, 32'h8000_0020, 32'ha1b2_c3d4, 32'h0, 0);
        add_row(1, lsu_size_byte, 0, 32'h8000_0021, 32'h0000_00e5, 32'h0, 0);
        add_row(1, lsu_size_half, 0, 32'h8000_0022, 32'h0000_7f86, 32'h0, 0);
        add_row(1, lsu_size_byte, 0, 32'h8000_0023, 32'h0000_005c, 32'h0, 0);
        add_row(1, lsu_size_half, 0, 32'h8000_0020, 32'h0000_0b1e, 32'h0, 0);
        add_row(1, lsu_size_byte, 0, 32'h8000_0020, 32'h0000_0099, 32'h0, 0);
        add_row(1, lsu_size_byte, 0, 32'h8000_0022, 32'h0000_0042, 32'h0, 0);
        add_row(0, lsu_size_word, 0, 32'h8000_0020, 32'h0, 32'h5c42_0b99, 0);
        // narrow loads with and without sign
        add_row(1, lsu_size_word, 0, 32'h8000_0030, 32'h8a7f_e512, 32'h0, 0);
        add_row(0, lsu_size_byte, 1, 32'h8000_0030, 32'h0, 32'h0000_0012, 0);
        add_row(0, lsu_size_byte, 1, 32'h8000_0031, 32'h0, 32'hffff_ffe5, 0);
        add_row(0, lsu_size_byte, 0, 32'h8000_0031, 32'h0, 32'h0000_00e5, 0);
        add_row(0, lsu_size_byte, 1, 32'h8000_0032, 32'h0, 32'h0000_007f, 0);
        add_row(0, lsu_size_byte, 1, 32'h8000_0033, 32'h0, 32'hffff_ff8a, 0);
        add_row(0, lsu_size_byte, 0, 32'h8000_0033, 32'h0, 32'h0000_008a, 0);
        add_row(0, lsu_size_half, 1, 32'h8000_0030, 32'h0, 32'hffff_e512, 0);
        add_row(0, lsu_size_half, 0, 32'h8000_0030, 32'h0, 32'h0000_e512, 0);
        add_row(0, lsu_size_half, 1, 32'h8000_0032, 32'h0, 32'hffff_8a7f, 0);
        add_row(0, lsu_size_half, 0, 32'h8000_0032, 32'h0, 32'h0000_8a7f, 0);
        // mtime low word cleared, then mtimeh written and read back
        add_row(1, lsu_size_word, 0, 32'ha000_0048, 32'h0, 32'h0, 0);
        add_row(1, lsu_size_word, 0, 32'ha000_004c, 32'h1234_abcd, 32'h0, 0);
        add_row(0, lsu_size_word, 0, 32'ha000_004c, 32'h0, 32'h1234_abcd, 0);
        // error page
        add_row(0, lsu_size_word, 0, 32'h8000_1004, 32'h0, 32'h0, 1);
        add_row(1, lsu_size_word, 0, 32'h8000_1008, 32'h0bad_0bad, 32'h0, 1);
        rows_ready = 1'b1;

        credits  = `LSU_CREDITS;
        n_sent   = 0;
        n_resp   = 0;
        n_credit = 0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        while (n_resp < rows.size()) begin
            @(posedge clk);
            #1;
            if (n_sent < rows.size() && credits != 0) begin
                r = rows[n_sent];
                req_valid = 1'b1;
                req_we    = r.we;
                req_sign  = r.sgn;
                req_size  = r.sz;
                req_addr  = r.addr;
                req_wdata = r.wdata;
                exp_q.push_back(n_sent);
                if (!in_clint(r.addr)) begin
                    axi_q.push_back(n_sent);
                end
                n_sent++;
                credits--;
            end else begin
                req_valid = 1'b0;
            end
            @(negedge clk);
            if (credit_return) begin
                if (credits == `LSU_CREDITS) begin
                    abort_run("credit returned beyond the number handed out");
                end
                credits++;
                n_credit++;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("response arrived with no request outstanding");
                end
                idx = exp_q.pop_front();
                check_err("resp_err", resp_err, rows[idx].exp_err);
                if (!rows[idx].we && !rows[idx].exp_err) begin
                    check_data("resp_rdata", resp_rdata, rows[idx].exp_data);
                end
                n_resp++;
            end
        end

        // nothing more may come back
        repeat (5) begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            @(negedge clk);
            if (resp_valid || credit_return) begin
                abort_run("extra response or credit after all requests completed");
            end
        end

        if (n_credit == rows.size() && credits == `LSU_CREDITS
            && u_lsu_top.u_lsu_asserts.n_fail == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("credit count or bound assertions did not hold at the end");
            $display("=== FAIL ===");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

// ==== lsu_subsys.f ====
+incdir+include
design/lsu_pkg.sv
design/axi_pkg.sv
design/lsu_req_queue.sv
design/clint_regs.sv
design/axi_single_master.sv
design/lsu_resp_merge.sv
design/lsu_top.sv
sim/lsu_asserts.sv
sim/tb_lsu_top.sv
